// ==== verilog/tracker_pkg.sv ====
package tracker_pkg;

   // one rgb565 pixel, high byte first on the camera bus
   typedef logic [15:0] pixel565_t;

   // frame coordinates, sized for 320x180
   typedef logic [8:0] hcount_t;
   typedef logic [7:0] vcount_t;

   // single colour channel or chroma value
   typedef logic [7:0] chroma_t;

   // per-frame centroid accumulators
   typedef logic [24:0] sum_x_t;
   typedef logic [23:0] sum_y_t;
   typedef logic [16:0] pix_count_t;

   // centre of the chroma scale
   localparam chroma_t CHROMA_OFFSET = 8'd128;

   typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;

   typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_e;

   typedef enum logic [1:0] {rep_idle, rep_send_x, rep_send_y} report_state_e;

endpackage

// ==== verilog/camera_decode.sv ====
`timescale 1ns/100ps

module camera_decode (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   input  tracker_pkg::chroma_t   camera_d_i,
   input  logic                   cam_pclk_i,
   input  logic                   cam_hsync_i,
   input  logic                   cam_vsync_i,
   output logic                   pix_valid_o,
   output tracker_pkg::pixel565_t pix_data_o,
   output tracker_pkg::hcount_t   pix_hcount_o,
   output tracker_pkg::vcount_t   pix_vcount_o
);
   import tracker_pkg::*;

   // two-flop synchronizers, index 1 is the settled copy
   chroma_t    d_meta;
   chroma_t    d_sync;
   logic [1:0] pclk_ff;
   logic [1:0] hs_ff;
   logic [1:0] vs_ff;

   // previous settled values for edge detection
   logic pclk_prev;
   logic hs_prev;
   logic vs_prev;

   logic pclk_rise;
   logic hs_fall;
   logic vs_rise;

   // byte pairing and position counters
   logic    low_half;
   chroma_t high_byte;
   hcount_t col;
   vcount_t row;

   // data bus travels alongside the control pins
   always_ff @(posedge clk_camera) begin
      d_meta <= camera_d_i;
      d_sync <= d_meta;
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_ff   <= '0;
         hs_ff     <= '0;
         vs_ff     <= '0;
         pclk_prev <= 1'b0;
         hs_prev   <= 1'b0;
         vs_prev   <= 1'b0;
      end else begin
         pclk_ff   <= {pclk_ff[0], cam_pclk_i};
         hs_ff     <= {hs_ff[0], cam_hsync_i};
         vs_ff     <= {vs_ff[0], cam_vsync_i};
         pclk_prev <= pclk_ff[1];
         hs_prev   <= hs_ff[1];
         vs_prev   <= vs_ff[1];
      end
   end

   assign pclk_rise = pclk_ff[1] & ~pclk_prev;
   assign hs_fall   = ~hs_ff[1] & hs_prev;
   assign vs_rise   = vs_ff[1] & ~vs_prev;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pix_valid_o <= 1'b0;
         low_half    <= 1'b0;
         col         <= '0;
         row         <= '0;
      end else begin
         pix_valid_o <= 1'b0;
         if (vs_rise) begin
            // new frame
            col      <= '0;
            row      <= '0;
            low_half <= 1'b0;
         end else if (hs_fall) begin
            // end of line, next row
            col      <= '0;
            row      <= row + 1'b1;
            low_half <= 1'b0;
         end else if (pclk_rise && hs_ff[1]) begin
            if (!low_half) begin
               high_byte <= d_sync;
               low_half  <= 1'b1;
            end else begin
               // low byte completes the pixel
               pix_data_o   <= {high_byte, d_sync};
               pix_hcount_o <= col;
               pix_vcount_o <= row;
               pix_valid_o  <= 1'b1;
               col          <= col + 1'b1;
               low_half     <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== verilog/mask_execute.sv ====
`timescale 1ns/100ps

module mask_execute #(
   parameter int                   H_PIXELS        = 320,
   parameter int                   V_LINES         = 180,
   parameter tracker_pkg::chroma_t LOWER_THRESHOLD = 8'hA0,
   parameter tracker_pkg::chroma_t UPPER_THRESHOLD = 8'hF0
) (
   input  logic                     clk_camera,
   input  logic                     sys_rst_camera,
   input  logic                     pix_valid_i,
   input  tracker_pkg::pixel565_t   pix_data_i,
   input  tracker_pkg::hcount_t     pix_hcount_i,
   input  tracker_pkg::vcount_t     pix_vcount_i,
   input  tracker_pkg::hcount_t     centroid_x_i,
   input  tracker_pkg::vcount_t     centroid_y_i,
   input  logic                     div_ready_i,
   output logic                     pixel_valid_o,
   output logic                     mask_o,
   output logic                     crosshair_o,
   output logic                     div_start_o,
   output tracker_pkg::sum_x_t      sum_x_o,
   output tracker_pkg::sum_y_t      sum_y_o,
   output tracker_pkg::pix_count_t  pix_count_o
);
   import tracker_pkg::*;

   chroma_t           red8;
   chroma_t           green8;
   chroma_t           chroma;
   logic signed [9:0] diff;
   logic signed [9:0] chroma_wide;
   logic              in_window;
   logic              on_cross;
   logic              last_pix;

   // running sums and their values including the current pixel
   sum_x_t     acc_x;
   sum_y_t     acc_y;
   pix_count_t acc_n;
   sum_x_t     nxt_x;
   sum_y_t     nxt_y;
   pix_count_t nxt_n;

   always_comb begin
      // pad 5/6-bit channels up to 8 bits
      red8   = {pix_data_i[15:11], 3'b000};
      green8 = {pix_data_i[10:5], 2'b00};
      // cr-like chroma, the difference is always even so the halving is exact
      diff        = $signed({2'b00, red8}) - $signed({2'b00, green8});
      chroma_wide = $signed({2'b00, CHROMA_OFFSET}) + (diff >>> 1);
      chroma      = chroma_wide[7:0];
      in_window   = (chroma >= LOWER_THRESHOLD) && (chroma <= UPPER_THRESHOLD);
      on_cross    = (pix_hcount_i == centroid_x_i) || (pix_vcount_i == centroid_y_i);
      last_pix    = (pix_hcount_i == hcount_t'(H_PIXELS - 1)) &&
                    (pix_vcount_i == vcount_t'(V_LINES - 1));
      nxt_x = acc_x + (in_window ? sum_x_t'(pix_hcount_i) : '0);
      nxt_y = acc_y + (in_window ? sum_y_t'(pix_vcount_i) : '0);
      nxt_n = acc_n + (in_window ? pix_count_t'(1) : '0);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pixel_valid_o <= 1'b0;
         mask_o        <= 1'b0;
         crosshair_o   <= 1'b0;
         div_start_o   <= 1'b0;
         acc_x         <= '0;
         acc_y         <= '0;
         acc_n         <= '0;
      end else begin
         pixel_valid_o <= pix_valid_i;
         div_start_o   <= 1'b0;
         if (pix_valid_i) begin
            mask_o      <= in_window;
            crosshair_o <= on_cross;
            if (last_pix) begin
               // hand over the whole frame, empty frames start nothing
               sum_x_o     <= nxt_x;
               sum_y_o     <= nxt_y;
               pix_count_o <= nxt_n;
               div_start_o <= (nxt_n != '0) && div_ready_i;
               acc_x       <= '0;
               acc_y       <= '0;
               acc_n       <= '0;
            end else begin
               acc_x <= nxt_x;
               acc_y <= nxt_y;
               acc_n <= nxt_n;
            end
         end
      end
   end

endmodule

// ==== verilog/centroid_divider.sv ====
`timescale 1ns/100ps

module centroid_divider (
   input  logic                    clk_camera,
   input  logic                    sys_rst_camera,
   input  logic                    start_i,
   input  tracker_pkg::sum_x_t     sum_x_i,
   input  tracker_pkg::sum_y_t     sum_y_i,
   input  tracker_pkg::pix_count_t count_i,
   output logic                    ready_o,
   output tracker_pkg::hcount_t    centroid_x_o,
   output tracker_pkg::vcount_t    centroid_y_o,
   output logic                    centroid_valid_o
);
   import tracker_pkg::*;

   // one quotient bit per cycle over the wider sum
   localparam int STEPS = $bits(sum_x_t);
   localparam int CNT_W = $clog2(STEPS);
   localparam int REM_W = $bits(pix_count_t);

   div_state_e       state;
   logic [CNT_W-1:0] step;
   pix_count_t       divisor;
   // dividend shifts out the top while quotient bits shift in
   sum_x_t           quo_x;
   sum_x_t           quo_y;
   pix_count_t       rem_x;
   pix_count_t       rem_y;
   logic [REM_W:0]   trial_x;
   logic [REM_W:0]   trial_y;
   logic             ge_x;
   logic             ge_y;

   assign trial_x = {rem_x, quo_x[STEPS-1]};
   assign trial_y = {rem_y, quo_y[STEPS-1]};
   assign ge_x    = trial_x >= {1'b0, divisor};
   assign ge_y    = trial_y >= {1'b0, divisor};
   assign ready_o = (state == div_idle);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state            <= div_idle;
         centroid_x_o     <= '0;
         centroid_y_o     <= '0;
         centroid_valid_o <= 1'b0;
      end else begin
         centroid_valid_o <= 1'b0;
         case (state)
            div_idle: if (start_i) begin
               quo_x   <= sum_x_i;
               quo_y   <= sum_x_t'(sum_y_i);
               divisor <= count_i;
               rem_x   <= '0;
               rem_y   <= '0;
               step    <= CNT_W'(STEPS - 1);
               state   <= div_run;
            end
            div_run: begin
               // restore by keeping the trial value when it is below the divisor
               rem_x <= ge_x ? REM_W'(trial_x - {1'b0, divisor}) : trial_x[REM_W-1:0];
               rem_y <= ge_y ? REM_W'(trial_y - {1'b0, divisor}) : trial_y[REM_W-1:0];
               quo_x <= {quo_x[STEPS-2:0], ge_x};
               quo_y <= {quo_y[STEPS-2:0], ge_y};
               if (step == '0) state <= div_done;
               else step <= step - 1'b1;
            end
            div_done: begin
               // means always fit the frame coordinates
               centroid_x_o     <= quo_x[$bits(hcount_t)-1:0];
               centroid_y_o     <= quo_y[$bits(vcount_t)-1:0];
               centroid_valid_o <= 1'b1;
               state            <= div_idle;
            end
            default: state <= div_idle;
         endcase
      end
   end

endmodule

// ==== verilog/report_result.sv ====
`timescale 1ns/100ps

module report_result (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  tracker_pkg::hcount_t centroid_x_i,
   input  tracker_pkg::vcount_t centroid_y_i,
   input  logic                 centroid_valid_i,
   input  logic                 tx_busy_i,
   output tracker_pkg::chroma_t tx_byte_o,
   output logic                 tx_start_o
);
   import tracker_pkg::*;

   report_state_e state;
   logic          pending;
   hcount_t       pend_x;
   vcount_t       pend_y;
   // y of the report being sent, kept apart from newer centroids
   vcount_t       cur_y;
   hcount_t       new_x;
   vcount_t       new_y;
   logic          have_new;

   // bypass so a fresh centroid can go out on the next cycle
   assign new_x    = centroid_valid_i ? centroid_x_i : pend_x;
   assign new_y    = centroid_valid_i ? centroid_y_i : pend_y;
   assign have_new = centroid_valid_i | pending;

   always_ff @(posedge clk_camera) begin
      pend_x <= new_x;
      pend_y <= new_y;
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state      <= rep_idle;
         pending    <= 1'b0;
         tx_start_o <= 1'b0;
      end else begin
         tx_start_o <= 1'b0;
         // newest centroid wins over one still waiting
         if (centroid_valid_i) pending <= 1'b1;
         case (state)
            rep_idle: if (have_new && !tx_busy_i) begin
               tx_byte_o  <= new_x[8:1];
               cur_y      <= new_y;
               tx_start_o <= 1'b1;
               pending    <= 1'b0;
               state      <= rep_send_x;
            end
            // busy rises the cycle after start, so skip that cycle
            rep_send_x: if (!tx_start_o && !tx_busy_i) begin
               tx_byte_o  <= cur_y;
               tx_start_o <= 1'b1;
               state      <= rep_send_y;
            end
            rep_send_y: if (!tx_start_o && !tx_busy_i) state <= rep_idle;
            default: state <= rep_idle;
         endcase
      end
   end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 868
) (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  tracker_pkg::chroma_t byte_i,
   input  logic                 start_i,
   output logic                 busy_o,
   output logic                 txd_o
);
   import tracker_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT);

   uart_state_e state;
   logic [CW-1:0] clk_cnt;
   logic [2:0]    bit_idx;
   chroma_t       shift;
   logic          bit_end;

   assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
   assign busy_o  = (state != uart_idle);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state   <= uart_idle;
         txd_o   <= 1'b1;
         clk_cnt <= '0;
         bit_idx <= '0;
      end else begin
         clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
         case (state)
            uart_idle: begin
               txd_o   <= 1'b1;
               clk_cnt <= '0;
               if (start_i) begin
                  shift <= byte_i;
                  txd_o <= 1'b0;
                  state <= uart_start;
               end
            end
            uart_start: if (bit_end) begin
               // lsb first
               txd_o   <= shift[0];
               bit_idx <= '0;
               state   <= uart_data;
            end
            uart_data: if (bit_end) begin
               if (bit_idx == 3'd7) begin
                  txd_o <= 1'b1;
                  state <= uart_stop;
               end else begin
                  txd_o   <= shift[1];
                  shift   <= {1'b0, shift[7:1]};
                  bit_idx <= bit_idx + 1'b1;
               end
            end
            uart_stop: if (bit_end) state <= uart_idle;
            default: state <= uart_idle;
         endcase
      end
   end

endmodule

// ==== verilog/baton_tracker_top.sv ====
`timescale 1ns/100ps

module baton_tracker_top #(
   parameter int                   H_PIXELS        = 320,
   parameter int                   V_LINES         = 180,
   parameter tracker_pkg::chroma_t LOWER_THRESHOLD = 8'hA0,
   parameter tracker_pkg::chroma_t UPPER_THRESHOLD = 8'hF0,
   parameter int                   CLKS_PER_BIT    = 868
) (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  tracker_pkg::chroma_t camera_d_i,
   input  logic                 cam_pclk_i,
   input  logic                 cam_hsync_i,
   input  logic                 cam_vsync_i,
   output logic                 pixel_valid_o,
   output logic                 mask_o,
   output logic                 crosshair_o,
   output tracker_pkg::hcount_t centroid_x_o,
   output tracker_pkg::vcount_t centroid_y_o,
   output logic                 centroid_valid_o,
   output logic                 uart_txd_o
);
   import tracker_pkg::*;

   // decode to execute
   logic      pix_valid;
   pixel565_t pix_data;
   hcount_t   pix_hcount;
   vcount_t   pix_vcount;

   // execute to divider
   logic       div_start;
   logic       div_ready;
   sum_x_t     sum_x;
   sum_y_t     sum_y;
   pix_count_t pix_count;

   // result to uart
   chroma_t tx_byte;
   logic    tx_start;
   logic    tx_busy;

   camera_decode u_decode (
      .clk_camera, .sys_rst_camera, .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
      .pix_valid_o(pix_valid), .pix_data_o(pix_data),
      .pix_hcount_o(pix_hcount), .pix_vcount_o(pix_vcount)
   );

   mask_execute #(
      .H_PIXELS(H_PIXELS), .V_LINES(V_LINES),
      .LOWER_THRESHOLD(LOWER_THRESHOLD), .UPPER_THRESHOLD(UPPER_THRESHOLD)
   ) u_execute (
      .clk_camera, .sys_rst_camera,
      .pix_valid_i(pix_valid), .pix_data_i(pix_data),
      .pix_hcount_i(pix_hcount), .pix_vcount_i(pix_vcount),
      .centroid_x_i(centroid_x_o), .centroid_y_i(centroid_y_o), .div_ready_i(div_ready),
      .pixel_valid_o, .mask_o, .crosshair_o,
      .div_start_o(div_start), .sum_x_o(sum_x), .sum_y_o(sum_y), .pix_count_o(pix_count)
   );

   centroid_divider u_divider (
      .clk_camera, .sys_rst_camera,
      .start_i(div_start), .sum_x_i(sum_x), .sum_y_i(sum_y), .count_i(pix_count),
      .ready_o(div_ready), .centroid_x_o, .centroid_y_o, .centroid_valid_o
   );

   report_result u_result (
      .clk_camera, .sys_rst_camera,
      .centroid_x_i(centroid_x_o), .centroid_y_i(centroid_y_o),
      .centroid_valid_i(centroid_valid_o), .tx_busy_i(tx_busy),
      .tx_byte_o(tx_byte), .tx_start_o(tx_start)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
      .clk_camera, .sys_rst_camera,
      .byte_i(tx_byte), .start_i(tx_start), .busy_o(tx_busy), .txd_o(uart_txd_o)
   );

endmodule

// ==== dv/tb_baton_tracker.sv ====
`timescale 1ns/100ps

module tb_baton_tracker;

   localparam int H_PIXELS      = 16;
   localparam int V_LINES       = 8;
   localparam int CLKS_PER_BIT  = 4;
   localparam logic [7:0] LOWER = 8'hA0;
   localparam logic [7:0] UPPER = 8'hF0;
   // centre of the chroma scale
   localparam int CHROMA_OFFSET = 128;

   // camera timing in clock cycles
   localparam int PCLK_HALF    = 3;
   localparam int HGAP_CYCLES  = 4;
   localparam int VSYNC_CYCLES = 4;
   localparam int VGAP_CYCLES  = 40;
   localparam int NUM_FRAMES   = 5;
   localparam int LINE_CYCLES  = H_PIXELS * 4 * PCLK_HALF + HGAP_CYCLES;
   localparam int FRAME_CYCLES = VSYNC_CYCLES + VGAP_CYCLES + V_LINES * LINE_CYCLES;
   // six frames plus margin for reset and the last report
   localparam int CYCLE_LIMIT  = 6 * FRAME_CYCLES + 400;

   logic       clk_camera;
   logic       sys_rst_camera;
   logic [7:0] camera_d_i;
   logic       cam_pclk_i;
   logic       cam_hsync_i;
   logic       cam_vsync_i;
   logic       pixel_valid_o;
   logic       mask_o;
   logic       crosshair_o;
   logic [8:0] centroid_x_o;
   logic [7:0] centroid_y_o;
   logic       centroid_valid_o;
   logic       uart_txd_o;

   // expected traffic filled by the camera model
   logic [15:0] pix_q[$];
   int          col_q[$];
   int          row_q[$];
   int          cx_q[$];
   int          cy_q[$];
   logic [7:0]  byte_q[$];

   // last centroid the model expects on the outputs
   int ref_cx = 0;
   int ref_cy = 0;
   int errors = 0;
   int n_pixels = 0;
   int n_centroids = 0;
   int n_bytes = 0;
   int cycles = 0;

   baton_tracker_top #(
      .H_PIXELS(H_PIXELS), .V_LINES(V_LINES),
      .LOWER_THRESHOLD(LOWER), .UPPER_THRESHOLD(UPPER), .CLKS_PER_BIT(CLKS_PER_BIT)
   ) dut (
      .clk_camera, .sys_rst_camera, .camera_d_i, .cam_pclk_i, .cam_hsync_i, .cam_vsync_i,
      .pixel_valid_o, .mask_o, .crosshair_o, .centroid_x_o, .centroid_y_o,
      .centroid_valid_o, .uart_txd_o
   );

   initial begin : clock_gen
      clk_camera = 1'b0;
      forever #20 clk_camera = ~clk_camera;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // cr-like chroma from rgb565 with channels padded to 8 bits
   function automatic int model_chroma(input logic [15:0] p);
      int r8;
      int g8;
      r8 = int'(p[15:11]) * 8;
      g8 = int'(p[10:5]) * 4;
      return CHROMA_OFFSET + (r8 - g8) / 2;
   endfunction

   function automatic logic in_window(input int chroma);
      return (chroma >= int'(LOWER)) && (chroma <= int'(UPPER));
   endfunction

   function automatic logic [15:0] chosen_pixel(input int k);
      case (k % 5)
         0: return 16'h4000;       // chroma 0xA0 at the lower bound
         1: return 16'hE000;       // chroma 0xF0 at the upper bound
         2: return 16'h4020;       // 0x9E just below
         3: return 16'hE820;       // 0xF2 just above
         default: return 16'hC100; // 0xD0 mid window
      endcase
   endfunction

   function automatic logic [15:0] make_pixel(input int frame, input int k,
                                              input logic [31:0] rnd);
      // frame 1 has no red so nothing reaches the window
      if (frame == 1) return rnd[15:0] & 16'h07FF;
      if (frame == 2) return chosen_pixel(k) | {11'd0, rnd[4:0]};
      if (rnd[31:30] == 2'b00) return chosen_pixel(int'(rnd[29:27])) | {11'd0, rnd[4:0]};
      return rnd[15:0];
   endfunction

   task automatic count_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
      errors++;
      $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
   endtask

   task automatic note_failure(input string msg);
      errors++;
      $display("%s at %0t", msg, $time);
   endtask

   task automatic print_summary();
      $display("errors %0d, pixels %0d, centroids %0d, uart bytes %0d",
               errors, n_pixels, n_centroids, n_bytes);
   endtask

   // n rising edges plus the drive offset
   task automatic step(input int n);
      repeat (n) @(posedge clk_camera);
      #2;
   endtask

   // byte is set with pclk low and held through the high phase
   task automatic drive_byte(input logic [7:0] b);
      camera_d_i = b;
      cam_pclk_i = 1'b0;
      step(PCLK_HALF);
      cam_pclk_i = 1'b1;
      step(PCLK_HALF);
   endtask

   initial begin : stimulus
      logic [31:0] rng;
      logic [15:0] pix;
      int          sum_x;
      int          sum_y;
      int          n_mask;
      rng            = 32'd77708;
      sys_rst_camera = 1'b1;
      camera_d_i     = 8'h00;
      cam_pclk_i     = 1'b0;
      cam_hsync_i    = 1'b0;
      cam_vsync_i    = 1'b0;
      step(5);
      sys_rst_camera = 1'b0;
      step(4);
      for (int f = 0; f < NUM_FRAMES; f++) begin
         sum_x  = 0;
         sum_y  = 0;
         n_mask = 0;
         cam_vsync_i = 1'b1;
         step(VSYNC_CYCLES);
         cam_vsync_i = 1'b0;
         // long enough for the previous centroid to land first
         step(VGAP_CYCLES);
         for (int r = 0; r < V_LINES; r++) begin
            cam_hsync_i = 1'b1;
            for (int c = 0; c < H_PIXELS; c++) begin
               rng = lcg_next(rng);
               pix = make_pixel(f, c + r, rng);
               pix_q.push_back(pix);
               col_q.push_back(c);
               row_q.push_back(r);
               if (in_window(model_chroma(pix))) begin
                  sum_x += c;
                  sum_y += r;
                  n_mask++;
               end
               drive_byte(pix[15:8]);
               drive_byte(pix[7:0]);
            end
            cam_pclk_i  = 1'b0;
            cam_hsync_i = 1'b0;
            step(HGAP_CYCLES);
         end
         // truncated means and the two report bytes
         if (n_mask != 0) begin
            cx_q.push_back(sum_x / n_mask);
            cy_q.push_back(sum_y / n_mask);
            byte_q.push_back(8'((sum_x / n_mask) >> 1));
            byte_q.push_back(8'(sum_y / n_mask));
         end
      end
      while (cx_q.size() != 0 || byte_q.size() != 0) step(1);
      // room for a stray extra byte to show up
      step(CLKS_PER_BIT * 12);
      if (pix_q.size() != 0) note_failure("driven pixels never came out of the DUT");
      print_summary();
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // pixel, crosshair and centroid checks on the falling edge
   always @(negedge clk_camera) begin : check_outputs
      logic [15:0] p;
      int          c;
      int          r;
      logic        exp_mask;
      logic        exp_cross;
      if (!sys_rst_camera) begin
         if (pixel_valid_o) begin
            if (pix_q.size() == 0) begin
               note_failure("pixel_valid_o raised with no pixel driven");
            end else begin
               p = pix_q.pop_front();
               c = col_q.pop_front();
               r = row_q.pop_front();
               exp_mask  = in_window(model_chroma(p));
               exp_cross = (c == ref_cx) || (r == ref_cy);
               n_pixels++;
               assert (mask_o == exp_mask)
                  else count_mismatch("mask_o", exp_mask, mask_o);
               assert (crosshair_o == exp_cross)
                  else count_mismatch("crosshair_o", exp_cross, crosshair_o);
               // centroid holds through frames and reads zero before the first
               assert (centroid_x_o == ref_cx[8:0])
                  else count_mismatch("centroid_x_o", ref_cx, centroid_x_o);
               assert (centroid_y_o == ref_cy[7:0])
                  else count_mismatch("centroid_y_o", ref_cy, centroid_y_o);
            end
         end
         if (centroid_valid_o) begin
            if (cx_q.size() == 0) begin
               note_failure("centroid_valid_o pulsed with no centroid expected");
            end else begin
               ref_cx = cx_q.pop_front();
               ref_cy = cy_q.pop_front();
               n_centroids++;
               assert (centroid_x_o == ref_cx[8:0])
                  else count_mismatch("centroid_x_o", ref_cx, centroid_x_o);
               assert (centroid_y_o == ref_cy[7:0])
                  else count_mismatch("centroid_y_o", ref_cy, centroid_y_o);
            end
         end
      end
   end

   // 8N1 receiver sampling near the middle of each bit
   initial begin : uart_receiver
      logic [7:0] rx;
      logic [7:0] exp_b;
      forever begin
         @(negedge clk_camera);
         if (!sys_rst_camera && uart_txd_o !== 1'b1) begin
            @(negedge clk_camera);
            if (uart_txd_o !== 1'b0) note_failure("uart start bit did not stay low");
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk_camera);
               rx[i] = uart_txd_o;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_camera);
            if (uart_txd_o !== 1'b1) note_failure("uart stop bit missing");
            if (byte_q.size() == 0) begin
               note_failure("uart byte sent with no report expected");
            end else begin
               exp_b = byte_q.pop_front();
               n_bytes++;
               assert (rx == exp_b)
                  else count_mismatch("uart_txd_o byte", exp_b, rx);
            end
         end
      end
   end

   initial begin : watchdog
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk_camera);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d centroids and %0d uart bytes outstanding",
               cycles, cx_q.size(), byte_q.size());
      print_summary();
      $display("** FAIL **");
      $finish;
   end

endmodule

// ==== all.f ====
verilog/tracker_pkg.sv
verilog/camera_decode.sv
verilog/mask_execute.sv
verilog/centroid_divider.sv
verilog/report_result.sv
verilog/uart_tx.sv
verilog/baton_tracker_top.sv
dv/tb_baton_tracker.sv

// ==== Bender.yml ====
package:
  name: baton_tracker

sources:
  - verilog/tracker_pkg.sv
  - verilog/camera_decode.sv
  - verilog/mask_execute.sv
  - verilog/centroid_divider.sv
  - verilog/report_result.sv
  - verilog/uart_tx.sv
  - verilog/baton_tracker_top.sv
  - target: test
    files:
      - dv/tb_baton_tracker.sv
